/* tests/natv_cases.txt */
# columns: test op addr wdata strb expected mask budget (test and budget decimal, rest hex)
# op: W write, R read and compare, P poll until match, G set gpio_in_i, I/O/E check irq_o/gpio_out_o/gpio_oe_o
0 I 00000000 00000000 0 00000000 00000003 0
0 O 00000000 00000000 0 00000000 0000ffff 0
0 E 00000000 00000000 0 00000000 0000ffff 0
0 R 10000000 00000000 0 00000000 ffffffff 0
1 W 10000000 a5a51234 f 00000000 00000000 0
1 R 10000000 00000000 0 00001234 ffffffff 0
1 W 10000000 0000ab00 2 00000000 00000000 0
1 R 10000000 00000000 0 0000ab34 ffffffff 0
1 W 10000000 000000cd 1 00000000 00000000 0
1 R 10000000 00000000 0 0000abcd ffffffff 0
1 O 00000000 00000000 0 0000abcd 0000ffff 0
1 W 10000004 000000ff f 00000000 00000000 0
1 W 10000004 00005a00 2 00000000 00000000 0
1 R 10000004 00000000 0 00005aff ffffffff 0
1 E 00000000 00000000 0 00005aff 0000ffff 0
2 G 00000000 0001c3e7 0 00000000 00000000 0
2 R 10000008 00000000 0 0000c3e7 ffffffff 0
2 W 10000008 0000ffff f 00000000 00000000 0
2 R 10000008 00000000 0 0000c3e7 ffffffff 0
2 R 10000000 00000000 0 0000abcd ffffffff 0
3 R 10005000 00000000 0 00000000 ffffffff 0
3 R 20000000 00000000 0 00000000 ffffffff 0
3 W 10005004 12345678 f 00000000 00000000 0
3 R 10000004 00000000 0 00005aff ffffffff 0
4 W 10002004 00000001 f 00000000 00000000 0
4 W 10002008 00000003 f 00000000 00000000 0
4 R 10002004 00000000 0 00000001 ffffffff 0
4 R 10002008 00000000 0 00000003 ffffffff 0
4 W 10002000 00000003 f 00000000 00000000 0
5 R 1000300c 00000000 0 00000000 ffffffff 0
5 R 10003000 00000000 0 00000000 ffffffff 0
5 I 00000000 00000000 0 00000000 00000002 0
6 P 10002010 00000000 0 00000001 00000001 28
6 I 00000000 00000000 0 00000001 00000001 0
6 W 10002000 00000002 f 00000000 00000000 0
6 W 10002010 00000001 f 00000000 00000000 0
6 R 10002010 00000000 0 00000000 ffffffff 0
6 I 00000000 00000000 0 00000000 00000003 0
7 W 10002000 00000001 f 00000000 00000000 0
7 P 10002010 00000000 0 00000001 00000001 28
7 I 00000000 00000000 0 00000000 00000001 0
7 W 10002010 00000000 f 00000000 00000000 0
7 R 10002010 00000000 0 00000001 00000001 0
7 W 10002000 00000000 f 00000000 00000000 0
7 W 10002010 00000001 f 00000000 00000000 0
7 R 10002010 00000000 0 00000000 ffffffff 0

/* compile.f */
design/nmi_pkg.sv
design/periph_pkg.sv
design/nmi_if.sv
design/simple_gpio.sv
design/simple_timer.sv
design/ip_natv_wrapper.sv
design/natv_subsys_top.sv
tests/natv_subsys_asserts.sv
tests/tb_natv_subsys.sv

/* Makefile */
# Verilator build and run for the native bus peripheral subsystem

VERILATOR ?= verilator
TOP       ?= tb_natv_subsys
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run, fails unless the log holds the pass line"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP BUILD_DIR LOG FILELIST VFLAGS"

$(SIM): $(SRCS) $(FILELIST)
	@mkdir -p $(BUILD_DIR)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM)
	@mkdir -p $(dir $(LOG))
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "test passed" $(LOG); then \
		echo "simulation log $(LOG) reports success"; \
	else \
		echo "simulation log $(LOG) reports failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

/* tests/tb_natv_subsys.sv */
// testbench for the native bus peripheral subsystem, replays the access list in tests/natv_cases.txt
`timescale 1ns/1ps

module tb_natv_subsys import nmi_pkg::*; ();

  localparam int GPIO_WIDTH = 16;
  // a mapped slave answers on the second cycle, anything past this is a hang
  localparam int ACCESS_WAIT = 8;
  localparam string CASE_FILE = "tests/natv_cases.txt";

  logic                  clk_i;
  logic                  reset_i;
  logic                  nmi_valid_i;
  logic [ADDR_W-1:0]     nmi_addr_i;
  logic [DATA_W-1:0]     nmi_wdata_i;
  logic [STRB_W-1:0]     nmi_wstrb_i;
  logic                  nmi_ready_o;
  logic [DATA_W-1:0]     nmi_rdata_o;
  logic [GPIO_WIDTH-1:0] gpio_in_i;
  logic [GPIO_WIDTH-1:0] gpio_out_o;
  logic [GPIO_WIDTH-1:0] gpio_oe_o;
  logic [NUM_IRQ-1:0]    irq_o;

  // case table, one entry per line of the case file
  int          tnum_q[$];
  logic [7:0]  op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] wdata_q[$];
  logic [31:0] strb_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] mask_q[$];
  int          budget_q[$];

  int cycle_count = 0;
  int cycle_limit = 0;
  int test_errs   = 0;
  int total_errs  = 0;
  int pass_count  = 0;
  int fail_count  = 0;

  natv_subsys_top #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) natv_subsys_top_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .nmi_valid_i(nmi_valid_i),
    .nmi_addr_i (nmi_addr_i),
    .nmi_wdata_i(nmi_wdata_i),
    .nmi_wstrb_i(nmi_wstrb_i),
    .nmi_ready_o(nmi_ready_o),
    .nmi_rdata_o(nmi_rdata_o),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .irq_o      (irq_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // watchdog, limit is set once the case file is loaded
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
      $display("test failed");
      $finish;
    end
  end

  task automatic load_cases();
    int          fd;
    int          n;
    int          tn;
    int          bud;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] s;
    logic [31:0] e;
    logic [31:0] m;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("cannot open case file %s", CASE_FILE);
      total_errs++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      n = $sscanf(line, "%d %s %h %h %h %h %h %d", tn, op, a, w, s, e, m, bud);
      if (n != 8) begin
        $display("malformed case line: %s", line);
        total_errs++;
        continue;
      end
      tnum_q.push_back(tn);
      op_q.push_back(op);
      addr_q.push_back(a);
      wdata_q.push_back(w);
      strb_q.push_back(s);
      exp_q.push_back(e);
      mask_q.push_back(m);
      budget_q.push_back(bud);
    end
    $fclose(fd);
  endtask

  // one bus transfer, entered and left on a falling edge
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, output logic [31:0] rdata,
                            output bit ok);
    int waited;
    waited = 0;
    ok = 1'b0;
    rdata = '0;
    nmi_valid_i = 1'b1;
    nmi_addr_i  = addr;
    nmi_wdata_i = wdata;
    nmi_wstrb_i = strb;
    while (!ok && waited < ACCESS_WAIT) begin
      @(negedge clk_i);
      waited++;
      if (nmi_ready_o) begin
        rdata = nmi_rdata_o;
        ok = 1'b1;
      end
    end
    // request stays up through the completing edge
    if (ok) @(negedge clk_i);
    nmi_valid_i = 1'b0;
    nmi_wstrb_i = '0;
    if (!ok) begin
      $display("no ready for the access at %h within %0d cycles", addr, ACCESS_WAIT);
      test_errs++;
    end
  endtask

  task automatic check_value(input string name, input int tn, input logic [31:0] actual,
                             input logic [31:0] expected, input logic [31:0] mask);
    if ((actual & mask) != (expected & mask)) begin
      $display("error: test %0d %s expected %h got %h (mask %h)", tn, name,
               expected & mask, actual & mask, mask);
      test_errs++;
    end
  endtask

  task automatic poll_read(input int tn, input logic [31:0] addr, input logic [31:0] expected,
                           input logic [31:0] mask, input int budget);
    int          start;
    logic [31:0] rdata;
    bit          ok;
    bit          hit;
    start = cycle_count;
    hit = 1'b0;
    ok = 1'b1;
    while (!hit && ok && (cycle_count - start) <= budget) begin
      bus_access(addr, '0, '0, rdata, ok);
      if (ok && (rdata & mask) == (expected & mask)) hit = 1'b1;
    end
    if (!hit && ok) begin
      $display("test %0d: poll of %h never reached %h within %0d cycles", tn, addr,
               expected & mask, budget);
      test_errs++;
    end
  endtask

  task automatic run_case(input int idx);
    logic [31:0] rdata;
    bit          ok;
    int          tn;
    tn = tnum_q[idx];
    case (op_q[idx])
      "W": bus_access(addr_q[idx], wdata_q[idx], strb_q[idx][3:0], rdata, ok);
      "R": begin
        bus_access(addr_q[idx], '0, '0, rdata, ok);
        if (ok) check_value("nmi_rdata_o", tn, rdata, exp_q[idx], mask_q[idx]);
      end
      "P": poll_read(tn, addr_q[idx], exp_q[idx], mask_q[idx], budget_q[idx]);
      "G": begin
        gpio_in_i = wdata_q[idx][GPIO_WIDTH-1:0];
        // two synchronizer flops plus margin
        repeat (3) @(negedge clk_i);
      end
      "I": check_value("irq_o", tn, 32'(irq_o), exp_q[idx], mask_q[idx]);
      "O": check_value("gpio_out_o", tn, 32'(gpio_out_o), exp_q[idx], mask_q[idx]);
      "E": check_value("gpio_oe_o", tn, 32'(gpio_oe_o), exp_q[idx], mask_q[idx]);
      default: begin
        $display("test %0d: unknown operation code %h in the case file", tn, op_q[idx]);
        test_errs++;
      end
    endcase
  endtask

  task automatic finish_test(input int tn);
    if (test_errs == 0) begin
      $display("test %0d: ok", tn);
      pass_count++;
    end else begin
      $display("test %0d: %0d errors", tn, test_errs);
      fail_count++;
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  initial begin
    int budget_sum;
    reset_i     = 1'b1;
    nmi_valid_i = 1'b0;
    nmi_addr_i  = '0;
    nmi_wdata_i = '0;
    nmi_wstrb_i = '0;
    gpio_in_i   = '0;
    budget_sum  = 0;
    load_cases();
    foreach (budget_q[i]) budget_sum += budget_q[i];
    cycle_limit = 10 * tnum_q.size() + budget_sum + 100;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (int idx = 0; idx < tnum_q.size(); idx++) begin
      if (idx > 0 && tnum_q[idx] != tnum_q[idx-1]) finish_test(tnum_q[idx-1]);
      run_case(idx);
    end
    if (tnum_q.size() > 0) finish_test(tnum_q[tnum_q.size()-1]);
    $display("passing tests: %0d, failing tests: %0d", pass_count, fail_count);
    if (total_errs == 0 && fail_count == 0 && pass_count > 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* tests/natv_subsys_asserts.sv */
// handshake checks for the native bus decoder, attached to ip_natv_wrapper with bind
`timescale 1ns/1ps

module natv_subsys_asserts (
  input logic clk_i,
  input logic reset_i,
  input logic valid_i,
  input logic ready_i,
  input logic gpio_valid_i,
  input logic tim0_valid_i,
  input logic tim1_valid_i,
  input logic miss_valid_i,
  input logic gpio_ready_i,
  input logic tim0_ready_i,
  input logic tim1_ready_i,
  input logic miss_ready_i
);

  // a slave only raises its registered ready for its own pending request
  ready_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    ({gpio_ready_i, tim0_ready_i, tim1_ready_i, miss_ready_i} &
     ~{gpio_valid_i, tim0_valid_i, tim1_valid_i, miss_valid_i}) == 4'b0)
    else $error("slave ready high without its valid");

  // a waiting request is acked on the next edge, two cycles from valid
  ready_in_time: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i && !ready_i |=> ready_i)
    else $error("nmi ready missing two cycles after valid");

  one_slave_selected: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({gpio_valid_i, tim0_valid_i, tim1_valid_i}))
    else $error("more than one peripheral valid at once");

  ready_single_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    ready_i |=> !ready_i)
    else $error("nmi ready high in two consecutive cycles");

endmodule

bind ip_natv_wrapper natv_subsys_asserts u_natv_subsys_asserts (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .valid_i     (nmi.valid),
  .ready_i     (nmi.ready),
  .gpio_valid_i(u_gpio_nmi_if.valid),
  .tim0_valid_i(u_tim0_nmi_if.valid),
  .tim1_valid_i(u_tim1_nmi_if.valid),
  .miss_valid_i(miss_valid),
  .gpio_ready_i(u_gpio_nmi_if.ready),
  .tim0_ready_i(u_tim0_nmi_if.ready),
  .tim1_ready_i(u_tim1_nmi_if.ready),
  .miss_ready_i(miss_ready_q)
);

/* design/natv_subsys_top.sv */
// top level of the native bus peripheral subsystem, bus and gpio pins as plain ports
`timescale 1ns/1ps

module natv_subsys_top import nmi_pkg::*; #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // native bus from the core
  input  logic                  nmi_valid_i,
  input  logic [ADDR_W-1:0]     nmi_addr_i,
  input  logic [DATA_W-1:0]     nmi_wdata_i,
  input  logic [STRB_W-1:0]     nmi_wstrb_i,
  output logic                  nmi_ready_o,
  output logic [DATA_W-1:0]     nmi_rdata_o,
  // gpio pins
  input  logic [GPIO_WIDTH-1:0] gpio_in_i,
  output logic [GPIO_WIDTH-1:0] gpio_out_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o,
  // timer interrupts
  output logic [NUM_IRQ-1:0]    irq_o
);

  nmi_if u_nmi_if ();

  // bundle the bus pins, no added delay
  assign u_nmi_if.valid = nmi_valid_i;
  assign u_nmi_if.addr  = nmi_addr_i;
  assign u_nmi_if.wdata = nmi_wdata_i;
  assign u_nmi_if.wstrb = nmi_wstrb_i;

  assign nmi_ready_o = u_nmi_if.ready;
  assign nmi_rdata_o = u_nmi_if.rdata;

  ip_natv_wrapper #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) u_ip_natv_wrapper (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .nmi       (u_nmi_if),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oe_o (gpio_oe_o),
    .irq_o     (irq_o)
  );

endmodule

/* design/ip_natv_wrapper.sv */
// native bus decoder and response mux for the gpio and timer peripherals, with an unmapped responder
`timescale 1ns/1ps

module ip_natv_wrapper import nmi_pkg::*; #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  nmi_if.slave                  nmi,
  input  logic [GPIO_WIDTH-1:0] gpio_in_i,
  output logic [GPIO_WIDTH-1:0] gpio_out_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o,
  output logic [NUM_IRQ-1:0]    irq_o
);

  nmi_if u_gpio_nmi_if ();
  nmi_if u_tim0_nmi_if ();
  nmi_if u_tim1_nmi_if ();

  logic reg_space;
  logic gpio_hit;
  logic tim0_hit;
  logic tim1_hit;
  logic miss_valid;
  logic miss_ready_q;

  // address decode, slot in addr[15:8] only counts inside the register space
  assign reg_space = nmi.addr[31:24] == REG_SPACE;
  assign gpio_hit  = reg_space && nmi.addr[15:8] == GPIO_SLOT;
  assign tim0_hit  = reg_space && nmi.addr[15:8] == TIM0_SLOT;
  assign tim1_hit  = reg_space && nmi.addr[15:8] == TIM1_SLOT;

  assign u_gpio_nmi_if.valid = nmi.valid & gpio_hit;
  assign u_gpio_nmi_if.addr  = nmi.addr;
  assign u_gpio_nmi_if.wdata = nmi.wdata;
  assign u_gpio_nmi_if.wstrb = nmi.wstrb;

  assign u_tim0_nmi_if.valid = nmi.valid & tim0_hit;
  assign u_tim0_nmi_if.addr  = nmi.addr;
  assign u_tim0_nmi_if.wdata = nmi.wdata;
  assign u_tim0_nmi_if.wstrb = nmi.wstrb;

  assign u_tim1_nmi_if.valid = nmi.valid & tim1_hit;
  assign u_tim1_nmi_if.addr  = nmi.addr;
  assign u_tim1_nmi_if.wdata = nmi.wdata;
  assign u_tim1_nmi_if.wstrb = nmi.wstrb;

  // unmapped accesses get acked one cycle later so the master never hangs
  assign miss_valid = nmi.valid & ~(gpio_hit | tim0_hit | tim1_hit);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_ready_q <= 1'b0;
    end else begin
      miss_ready_q <= miss_valid & ~miss_ready_q;
    end
  end

  // and-or response mux, the responder adds ready but no data
  assign nmi.ready = (u_gpio_nmi_if.valid & u_gpio_nmi_if.ready) |
                     (u_tim0_nmi_if.valid & u_tim0_nmi_if.ready) |
                     (u_tim1_nmi_if.valid & u_tim1_nmi_if.ready) |
                     (miss_valid & miss_ready_q);

  assign nmi.rdata =
      ({DATA_W{u_gpio_nmi_if.valid & u_gpio_nmi_if.ready}} & u_gpio_nmi_if.rdata) |
      ({DATA_W{u_tim0_nmi_if.valid & u_tim0_nmi_if.ready}} & u_tim0_nmi_if.rdata) |
      ({DATA_W{u_tim1_nmi_if.valid & u_tim1_nmi_if.ready}} & u_tim1_nmi_if.rdata);

  simple_gpio #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) u_simple_gpio (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .nmi       (u_gpio_nmi_if),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oe_o (gpio_oe_o)
  );

  simple_timer u_simple_timer0 (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .nmi    (u_tim0_nmi_if),
    .irq_o  (irq_o[0])
  );

  simple_timer u_simple_timer1 (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .nmi    (u_tim1_nmi_if),
    .irq_o  (irq_o[1])
  );

endmodule

/* design/simple_timer.sv */
// prescaled compare timer on the native bus with a sticky overflow flag and a gated interrupt
`timescale 1ns/1ps

module simple_timer import nmi_pkg::*, periph_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  nmi_if.slave nmi,
  output logic irq_o
);

  logic              ready_q;
  logic              wr_en;
  logic [1:0]        ctrl_q;
  logic [DATA_W-1:0] psc_q;
  logic [DATA_W-1:0] cmp_q;
  logic [DATA_W-1:0] cnt_q;
  logic [DATA_W-1:0] psc_cnt_q;
  logic              ovf_q;

  // one-cycle ready pulse, rises the cycle after valid is first seen
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= nmi.valid & ~ready_q;
    end
  end

  // full-word writes on the completing edge, cnt is read only
  assign wr_en = nmi.valid & ready_q & (|nmi.wstrb);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q    <= '0;
      psc_q     <= '0;
      cmp_q     <= '0;
      cnt_q     <= '0;
      psc_cnt_q <= '0;
      ovf_q     <= 1'b0;
    end else begin
      // disabled timer holds both counters
      if (ctrl_q[TIM_EN_BIT]) begin
        // >= keeps the counters bounded if psc or cmp is lowered mid-count
        if (psc_cnt_q >= psc_q) begin
          psc_cnt_q <= '0;
          if (cnt_q >= cmp_q) begin
            cnt_q <= '0;
            ovf_q <= 1'b1;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end else begin
          psc_cnt_q <= psc_cnt_q + 1'b1;
        end
      end

      // bus write takes priority over a same-cycle overflow
      if (wr_en) begin
        case (nmi.addr[7:0])
          TIM_CTRL_OFS: begin
            ctrl_q[TIM_EN_BIT]    <= nmi.wdata[TIM_EN_BIT];
            ctrl_q[TIM_IRQEN_BIT] <= nmi.wdata[TIM_IRQEN_BIT];
          end
          TIM_PSC_OFS:  psc_q <= nmi.wdata;
          TIM_CMP_OFS:  cmp_q <= nmi.wdata;
          TIM_STAT_OFS: if (nmi.wdata[TIM_OVF_BIT]) ovf_q <= 1'b0;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    nmi.rdata = '0;
    case (nmi.addr[7:0])
      TIM_CTRL_OFS: begin
        nmi.rdata[TIM_EN_BIT]    = ctrl_q[TIM_EN_BIT];
        nmi.rdata[TIM_IRQEN_BIT] = ctrl_q[TIM_IRQEN_BIT];
      end
      TIM_PSC_OFS:  nmi.rdata = psc_q;
      TIM_CMP_OFS:  nmi.rdata = cmp_q;
      TIM_CNT_OFS:  nmi.rdata = cnt_q;
      TIM_STAT_OFS: nmi.rdata[TIM_OVF_BIT] = ovf_q;
      default: ;
    endcase
  end

  assign nmi.ready = ready_q;
  assign irq_o     = ovf_q & ctrl_q[TIM_IRQEN_BIT];

endmodule

/* design/simple_gpio.sv */
// gpio register block on the native bus, holds output and direction registers and samples the pins
`timescale 1ns/1ps

module simple_gpio import nmi_pkg::*, periph_pkg::*; #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  nmi_if.slave                  nmi,
  input  logic [GPIO_WIDTH-1:0] gpio_in_i,
  output logic [GPIO_WIDTH-1:0] gpio_out_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o
);

  logic                  ready_q;
  logic                  wr_en;
  logic [DATA_W-1:0]     strb_mask;
  logic [DATA_W-1:0]     out_merged;
  logic [DATA_W-1:0]     dir_merged;
  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] dir_q;
  logic [GPIO_WIDTH-1:0] in_meta_q;
  logic [GPIO_WIDTH-1:0] in_sync_q;

  // one-cycle ready pulse, rises the cycle after valid is first seen
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= nmi.valid & ~ready_q;
    end
  end

  // writes commit on the completing edge
  assign wr_en = nmi.valid & ready_q & (|nmi.wstrb);

  // expand byte strobes into a bit mask
  always_comb begin
    for (int i = 0; i < STRB_W; i++) begin
      strb_mask[8*i +: 8] = {8{nmi.wstrb[i]}};
    end
  end

  assign out_merged = (DATA_W'(out_q) & ~strb_mask) | (nmi.wdata & strb_mask);
  assign dir_merged = (DATA_W'(dir_q) & ~strb_mask) | (nmi.wdata & strb_mask);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (wr_en) begin
      if (nmi.addr[7:0] == GPIO_OUT_OFS) out_q <= out_merged[GPIO_WIDTH-1:0];
      if (nmi.addr[7:0] == GPIO_DIR_OFS) dir_q <= dir_merged[GPIO_WIDTH-1:0];
    end
  end

  // two-flop synchronizer for the asynchronous pins
  always_ff @(posedge clk_i) begin
    in_meta_q <= gpio_in_i;
    in_sync_q <= in_meta_q;
  end

  // read mux, bits above GPIO_WIDTH read as zero
  always_comb begin
    case (nmi.addr[7:0])
      GPIO_OUT_OFS: nmi.rdata = DATA_W'(out_q);
      GPIO_DIR_OFS: nmi.rdata = DATA_W'(dir_q);
      GPIO_IN_OFS:  nmi.rdata = DATA_W'(in_sync_q);
      default:      nmi.rdata = '0;
    endcase
  end

  assign nmi.ready  = ready_q;
  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;

endmodule

/* design/nmi_if.sv */
// native memory interface bundle, connects the bus decoder to each register-mapped peripheral
`timescale 1ns/1ps

interface nmi_if import nmi_pkg::*; ();

  // request, held stable by the master until ready is seen
  logic              valid;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;

  // response, rdata only meaningful while valid and ready are both high
  logic              ready;
  logic [DATA_W-1:0] rdata;

  modport master(
    output valid,
    output addr,
    output wdata,
    output wstrb,
    input  ready,
    input  rdata
  );

  modport slave(
    input  valid,
    input  addr,
    input  wdata,
    input  wstrb,
    output ready,
    output rdata
  );

endinterface

/* design/periph_pkg.sv */
// register offsets and control/status field positions for the gpio and timer peripherals
package periph_pkg;

  // gpio register offsets, addr[7:0]
  parameter logic [7:0] GPIO_OUT_OFS = 8'h00;
  parameter logic [7:0] GPIO_DIR_OFS = 8'h04;
  parameter logic [7:0] GPIO_IN_OFS  = 8'h08;

  // timer register offsets, addr[7:0]
  parameter logic [7:0] TIM_CTRL_OFS = 8'h00;
  parameter logic [7:0] TIM_PSC_OFS  = 8'h04;
  parameter logic [7:0] TIM_CMP_OFS  = 8'h08;
  parameter logic [7:0] TIM_CNT_OFS  = 8'h0C;
  parameter logic [7:0] TIM_STAT_OFS = 8'h10;

  // timer ctrl fields
  parameter int TIM_EN_BIT    = 0;
  parameter int TIM_IRQEN_BIT = 1;

  // timer stat fields, write 1 to clear
  parameter int TIM_OVF_BIT = 0;

endpackage

/* design/nmi_pkg.sv */
// native bus widths and register space address map, shared by the bus interface and decode logic
package nmi_pkg;

  // bus widths
  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;
  // all-zero strobe marks a read
  parameter int STRB_W = DATA_W / 8;

  // addr[31:24] selects the register space
  parameter logic [7:0] REG_SPACE = 8'h10;

  // addr[15:8] selects the peripheral inside the register space
  parameter logic [7:0] GPIO_SLOT = 8'h00;
  parameter logic [7:0] TIM0_SLOT = 8'h20;
  parameter logic [7:0] TIM1_SLOT = 8'h30;

  // one interrupt line per timer
  parameter int NUM_IRQ = 2;

endpackage
